/* design/ddr2_pkg.sv */
// shared widths, cycle timing, FSM codes and the command word for the ddr2 controller
package ddr2_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int BA_BITS        = 3;
    localparam int ROW_BITS       = 13;
    localparam int COL_BITS       = 10;
    localparam int ADDR_BITS      = 13;
    localparam int WORD_BITS      = 32;
    // burst is field value plus one words, field value odd
    localparam int LEN_BITS       = 8;
    localparam int HOST_ADDR_BITS = BA_BITS + ROW_BITS + COL_BITS;

    // --------------------
    // timing in clk1 cycles
    // --------------------
    localparam int REFI_CYCLES = 1560;
    localparam int RPA_CYCLES  = 4;
    localparam int RFC_CYCLES  = 26;
    localparam int WL          = 4;
    localparam int RL          = 5;
    localparam int WR_CYCLES   = 3;
    localparam int RTP_CYCLES  = 2;

    // a10 high on PRE means all banks
    localparam int ALLPRE_BIT = 10;
    localparam logic [ADDR_BITS-1:0] ALLPRE_ADDR = ADDR_BITS'(1 << ALLPRE_BIT);

    // counter widths and their compare or load values
    localparam int REFI_BITS    = $clog2(REFI_CYCLES);
    localparam int REF_CNT_BITS = $clog2(RPA_CYCLES + RFC_CYCLES + 1);
    localparam int PRE_CNT_BITS = $clog2(WL + WR_CYCLES + 1);
    localparam logic [REFI_BITS-1:0]    REFI_LAST     = REFI_BITS'(REFI_CYCLES - 1);
    localparam logic [REF_CNT_BITS-1:0] AREF_AT       = REF_CNT_BITS'(RPA_CYCLES);
    localparam logic [REF_CNT_BITS-1:0] REF_DONE_AT   = REF_CNT_BITS'(RPA_CYCLES + RFC_CYCLES);
    localparam logic [PRE_CNT_BITS-1:0] WR_RECOV_LOAD = PRE_CNT_BITS'(WL + WR_CYCLES);
    localparam logic [PRE_CNT_BITS-1:0] RD_RECOV_LOAD = PRE_CNT_BITS'(RTP_CYCLES + 1);
    localparam logic [PRE_CNT_BITS-1:0] RP_LOAD       = PRE_CNT_BITS'(RPA_CYCLES - 2);
    // one column command covers a word pair
    localparam logic [COL_BITS-1:0]     COL_STEP      = COL_BITS'(2);

    // --------------------
    // sequencer states
    // --------------------
    localparam int STATE_BITS = 3;
    localparam logic [STATE_BITS-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_BITS-1:0] ST_REFRESH   = 3'd1;
    localparam logic [STATE_BITS-1:0] ST_ACTIVATE  = 3'd2;
    localparam logic [STATE_BITS-1:0] ST_WRITE     = 3'd3;
    localparam logic [STATE_BITS-1:0] ST_READ      = 3'd4;
    localparam logic [STATE_BITS-1:0] ST_WR_RECOV  = 3'd5;
    localparam logic [STATE_BITS-1:0] ST_RD_TO_PRE = 3'd6;
    localparam logic [STATE_BITS-1:0] ST_PRECHARGE = 3'd7;

    // pin codes as {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP   = 4'b0111,
        CMD_PRE   = 4'b0010,
        CMD_AREF  = 4'b0001,
        CMD_ACT   = 4'b0011,
        CMD_WRITE = 4'b0100,
        CMD_READ  = 4'b0101
    } cmd_code_e;

    // written as a code, read back as pins
    typedef union packed {
        cmd_code_e code;
        struct packed {
            logic cs_n;
            logic ras_n;
            logic cas_n;
            logic we_n;
        } pins;
    } ddr_cmd_u;

endpackage

/* design/ddr2_req_stage.sv */
// request stage of the ddr2 controller; takes one host request and holds it for the sequencer
`timescale 1ns/100ps

module ddr2_req_stage (
    input  logic                                clk1,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [ddr2_pkg::HOST_ADDR_BITS-1:0] req_addr,
    input  logic [ddr2_pkg::LEN_BITS-1:0]       req_len,
    input  logic                                take,
    output logic                                req_ready,
    output logic                                hold_valid,
    output logic                                hold_write,
    output logic [ddr2_pkg::BA_BITS-1:0]        hold_ba,
    output logic [ddr2_pkg::ROW_BITS-1:0]       hold_row,
    output logic [ddr2_pkg::COL_BITS-1:0]       hold_col,
    output logic [ddr2_pkg::LEN_BITS-1:0]       hold_len
);

    logic                                accept;
    logic                                started;
    logic [ddr2_pkg::HOST_ADDR_BITS-1:0] addr_q;

    assign accept = req_valid && req_ready;

    // ready drops after a transfer, comes back once the sequencer takes the hold
    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            started    <= 1'b0;
            req_ready  <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            // ready stays low for the first cycle out of reset
            started   <= 1'b1;
            req_ready <= started && (!hold_valid || take) && !accept;
            if (accept) begin
                hold_valid <= 1'b1;
            end else if (take) begin
                hold_valid <= 1'b0;
            end
        end
    end

    // request fields
    always_ff @(posedge clk1) begin
        if (accept) begin
            hold_write <= req_write;
            addr_q     <= req_addr;
            hold_len   <= req_len;
        end
    end

    // flat address is {bank, row, column}
    assign hold_ba  = addr_q[ddr2_pkg::HOST_ADDR_BITS-1 -: ddr2_pkg::BA_BITS];
    assign hold_row = addr_q[ddr2_pkg::COL_BITS +: ddr2_pkg::ROW_BITS];
    assign hold_col = addr_q[ddr2_pkg::COL_BITS-1:0];

    // one request in flight at most
    assert property (@(posedge clk1) disable iff (!rst_n) accept |-> !hold_valid);

endmodule

/* design/ddr2_refresh_timer.sv */
// periodic refresh timer; raises a refresh request every interval until the sequencer acks
`timescale 1ns/100ps

module ddr2_refresh_timer (
    input  logic clk1,
    input  logic rst_n,
    input  logic ref_ack,
    output logic ref_req
);

    logic [ddr2_pkg::REFI_BITS-1:0] refi_cnt;
    logic                           tick;

    // end of one refresh interval
    assign tick = (refi_cnt == ddr2_pkg::REFI_LAST);

    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            refi_cnt <= '0;
            ref_req  <= 1'b0;
        end else begin
            // free running, keeps counting while refresh is serviced
            if (tick) begin
                refi_cnt <= '0;
            end else begin
                refi_cnt <= refi_cnt + 1'b1;
            end
            // a new tick wins over a late ack
            ref_req <= tick || (ref_req && !ref_ack);
        end
    end

endmodule

/* design/ddr2_cmd_seq.sv */
// command sequencer FSM; issues refresh, ACT, column commands and PRE ALL, paces write beats
`timescale 1ns/100ps

module ddr2_cmd_seq (
    input  logic                            clk1,
    input  logic                            rst_n,
    input  logic                            hold_valid,
    input  logic                            hold_write,
    input  logic [ddr2_pkg::BA_BITS-1:0]    hold_ba,
    input  logic [ddr2_pkg::ROW_BITS-1:0]   hold_row,
    input  logic [ddr2_pkg::COL_BITS-1:0]   hold_col,
    input  logic [ddr2_pkg::LEN_BITS-1:0]   hold_len,
    input  logic                            ref_req,
    output logic                            take,
    output logic                            ref_ack,
    output ddr2_pkg::ddr_cmd_u              cmd,
    output logic [ddr2_pkg::BA_BITS-1:0]    ba,
    output logic [ddr2_pkg::ADDR_BITS-1:0]  addr,
    output logic                            wr_ready,
    output logic                            wr_issue,
    output logic                            rd_issue,
    output logic                            wr_done
);

    logic [ddr2_pkg::STATE_BITS-1:0]   state;
    logic [ddr2_pkg::LEN_BITS-1:0]     beat_cnt;
    logic [ddr2_pkg::REF_CNT_BITS-1:0] ref_cnt;
    logic [ddr2_pkg::PRE_CNT_BITS-1:0] pre_cnt;
    logic [ddr2_pkg::COL_BITS-1:0]     col_ptr;
    logic [ddr2_pkg::LEN_BITS-1:0]     len_q;
    logic                              is_wr;
    logic                              wr_beat2;

    // host word pulled in the WRITE cycle and the one after
    assign wr_ready = wr_issue || wr_beat2;

    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ddr2_pkg::ST_IDLE;
            cmd.code <= ddr2_pkg::CMD_NOP;
            ba       <= '0;
            addr     <= '0;
            take     <= 1'b0;
            ref_ack  <= 1'b0;
            wr_issue <= 1'b0;
            rd_issue <= 1'b0;
            wr_done  <= 1'b0;
            wr_beat2 <= 1'b0;
            beat_cnt <= '0;
            ref_cnt  <= '0;
            pre_cnt  <= '0;
            col_ptr  <= '0;
            len_q    <= '0;
            is_wr    <= 1'b0;
        end else begin
            // pulses and NOP by default
            cmd.code <= ddr2_pkg::CMD_NOP;
            take     <= 1'b0;
            ref_ack  <= 1'b0;
            wr_issue <= 1'b0;
            rd_issue <= 1'b0;
            wr_done  <= 1'b0;
            wr_beat2 <= wr_issue;
            case (state)
                // --------------------
                // idle, refresh first
                // --------------------
                ddr2_pkg::ST_IDLE: begin
                    if (ref_req) begin
                        cmd.code <= ddr2_pkg::CMD_PRE;
                        addr     <= ddr2_pkg::ALLPRE_ADDR;
                        ref_ack  <= 1'b1;
                        // PRE already counted as step zero
                        ref_cnt  <= {{(ddr2_pkg::REF_CNT_BITS-1){1'b0}}, 1'b1};
                        state    <= ddr2_pkg::ST_REFRESH;
                    end else if (hold_valid) begin
                        cmd.code <= ddr2_pkg::CMD_ACT;
                        ba       <= hold_ba;
                        addr     <= hold_row;
                        col_ptr  <= hold_col;
                        len_q    <= hold_len;
                        is_wr    <= hold_write;
                        take     <= 1'b1;
                        state    <= ddr2_pkg::ST_ACTIVATE;
                    end
                end
                // PRE ALL went out from idle, AREF after tRPA, done after tRFC
                ddr2_pkg::ST_REFRESH: begin
                    ref_cnt <= ref_cnt + 1'b1;
                    if (ref_cnt == ddr2_pkg::AREF_AT) begin
                        cmd.code <= ddr2_pkg::CMD_AREF;
                    end else if (ref_cnt == ddr2_pkg::REF_DONE_AT) begin
                        state <= ddr2_pkg::ST_IDLE;
                    end
                end
                // first column command right after ACT
                ddr2_pkg::ST_ACTIVATE: begin
                    cmd.code <= is_wr ? ddr2_pkg::CMD_WRITE : ddr2_pkg::CMD_READ;
                    addr     <= {{(ddr2_pkg::ADDR_BITS-ddr2_pkg::COL_BITS){1'b0}}, col_ptr};
                    col_ptr  <= col_ptr + ddr2_pkg::COL_STEP;
                    wr_issue <= is_wr;
                    rd_issue <= !is_wr;
                    beat_cnt <= '0;
                    state    <= is_wr ? ddr2_pkg::ST_WRITE : ddr2_pkg::ST_READ;
                end
                // --------------------
                // burst, one column command per word pair
                // --------------------
                ddr2_pkg::ST_WRITE, ddr2_pkg::ST_READ: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt[0]) begin
                        cmd.code <= is_wr ? ddr2_pkg::CMD_WRITE : ddr2_pkg::CMD_READ;
                        addr     <= {{(ddr2_pkg::ADDR_BITS-ddr2_pkg::COL_BITS){1'b0}}, col_ptr};
                        col_ptr  <= col_ptr + ddr2_pkg::COL_STEP;
                        wr_issue <= is_wr;
                        rd_issue <= !is_wr;
                    end else if (beat_cnt == len_q - 1'b1) begin
                        // second beat of the last pair
                        if (is_wr) begin
                            pre_cnt <= ddr2_pkg::WR_RECOV_LOAD;
                            state   <= ddr2_pkg::ST_WR_RECOV;
                        end else begin
                            pre_cnt <= ddr2_pkg::RD_RECOV_LOAD;
                            state   <= ddr2_pkg::ST_RD_TO_PRE;
                        end
                    end
                end
                // write recovery or read-to-precharge, then PRE ALL
                ddr2_pkg::ST_WR_RECOV, ddr2_pkg::ST_RD_TO_PRE: begin
                    if (pre_cnt == '0) begin
                        cmd.code <= ddr2_pkg::CMD_PRE;
                        addr     <= ddr2_pkg::ALLPRE_ADDR;
                        pre_cnt  <= ddr2_pkg::RP_LOAD;
                        wr_done  <= (state == ddr2_pkg::ST_WR_RECOV);
                        state    <= ddr2_pkg::ST_PRECHARGE;
                    end else begin
                        pre_cnt <= pre_cnt - 1'b1;
                    end
                end
                // tRPA before the next ACT
                default: begin
                    if (pre_cnt == '0) begin
                        state <= ddr2_pkg::ST_IDLE;
                    end else begin
                        pre_cnt <= pre_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // pending refresh from the timer blocks any ACT out of idle
    assert property (@(posedge clk1) disable iff (!rst_n)
        (state == ddr2_pkg::ST_IDLE && ref_req) |=> (cmd.code != ddr2_pkg::CMD_ACT));

endmodule

/* design/ddr2_data_path.sv */
// data path; delays pulled write words onto dq by WL and returns read words RL+1 after READ
`timescale 1ns/100ps

module ddr2_data_path (
    input  logic                             clk1,
    input  logic                             rst_n,
    input  logic [ddr2_pkg::WORD_BITS-1:0]   wr_data,
    input  logic                             wr_ready,
    input  logic                             rd_issue,
    input  logic [ddr2_pkg::WORD_BITS-1:0]   dq_in,
    output logic [ddr2_pkg::WORD_BITS-1:0]   dq_out,
    output logic                             dq_oe,
    output logic                             rd_valid,
    output logic [ddr2_pkg::WORD_BITS-1:0]   rd_data
);

    logic [ddr2_pkg::WORD_BITS-1:0] wr_pipe [ddr2_pkg::WL];
    logic [ddr2_pkg::WL-1:0]        oe_pipe;
    logic [ddr2_pkg::RL-1:0]        rd_pipe;
    logic                           rd_beat2;
    logic                           rd_cap;

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk1) begin
        wr_pipe[0] <= wr_data;
        for (int i = 1; i < ddr2_pkg::WL; i++) begin
            wr_pipe[i] <= wr_pipe[i-1];
        end
    end

    // last stage drives the pins
    assign dq_out = wr_pipe[ddr2_pkg::WL-1];
    assign dq_oe  = oe_pipe[ddr2_pkg::WL-1];

    // --------------------
    // read side
    // --------------------
    // word 0 lands RL after READ, word 1 one cycle later
    assign rd_cap = rd_pipe[ddr2_pkg::RL-1] || rd_beat2;

    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            oe_pipe  <= '0;
            rd_pipe  <= '0;
            rd_beat2 <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            oe_pipe  <= {oe_pipe[ddr2_pkg::WL-2:0], wr_ready};
            // overlapping reads just ride the shift register
            rd_pipe  <= {rd_pipe[ddr2_pkg::RL-2:0], rd_issue};
            rd_beat2 <= rd_pipe[ddr2_pkg::RL-1];
            rd_valid <= rd_cap;
        end
    end

    always_ff @(posedge clk1) begin
        if (rd_cap) begin
            rd_data <= dq_in;
        end
    end

    // sequencer keeps write and read bursts apart on dq
    assert property (@(posedge clk1) disable iff (!rst_n) rd_cap |-> !dq_oe);

endmodule

/* design/ddr2_ctrl.sv */
// top of the ddr2 command controller; connects request stage, refresh timer, sequencer, data path
`timescale 1ns/100ps

module ddr2_ctrl (
    input  logic                                clk1,
    input  logic                                rst_n,
    // host request
    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic                                req_write,
    input  logic [ddr2_pkg::HOST_ADDR_BITS-1:0] req_addr,
    input  logic [ddr2_pkg::LEN_BITS-1:0]       req_len,
    // host data
    output logic                                wr_ready,
    input  logic [ddr2_pkg::WORD_BITS-1:0]      wr_data,
    output logic                                wr_done,
    output logic                                rd_valid,
    output logic [ddr2_pkg::WORD_BITS-1:0]      rd_data,
    // memory pins
    output logic                                cke,
    output logic                                cs_n,
    output logic                                ras_n,
    output logic                                cas_n,
    output logic                                we_n,
    output logic [ddr2_pkg::BA_BITS-1:0]        ba,
    output logic [ddr2_pkg::ADDR_BITS-1:0]      addr,
    output logic [ddr2_pkg::WORD_BITS-1:0]      dq_out,
    output logic                                dq_oe,
    input  logic [ddr2_pkg::WORD_BITS-1:0]      dq_in
);

    logic                          take;
    logic                          hold_valid;
    logic                          hold_write;
    logic [ddr2_pkg::BA_BITS-1:0]  hold_ba;
    logic [ddr2_pkg::ROW_BITS-1:0] hold_row;
    logic [ddr2_pkg::COL_BITS-1:0] hold_col;
    logic [ddr2_pkg::LEN_BITS-1:0] hold_len;
    logic                          ref_req;
    logic                          ref_ack;
    logic                          rd_issue;
    ddr2_pkg::ddr_cmd_u            cmd;

    ddr2_req_stage i_req_stage (.*);

    ddr2_refresh_timer i_refresh_timer (.*);

    // write issue pulse only paces wr_ready inside the sequencer
    ddr2_cmd_seq i_cmd_seq (
        .*,
        .wr_issue ()
    );

    ddr2_data_path i_data_path (.*);

    // command word out as separate pins
    assign cs_n  = cmd.pins.cs_n;
    assign ras_n = cmd.pins.ras_n;
    assign cas_n = cmd.pins.cas_n;
    assign we_n  = cmd.pins.we_n;

    // clock enable held high once out of reset
    always_ff @(posedge clk1 or negedge rst_n) begin
        if (!rst_n) begin
            cke <= 1'b0;
        end else begin
            cke <= 1'b1;
        end
    end

endmodule

/* tests/ddr2_mem_model.sv */
// behavioral ddr2 memory for the testbench; decodes pin commands, stores and returns words
`timescale 1ns/100ps

module ddr2_mem_model (
    input  logic                                clk1,
    input  logic                                cs_n,
    input  logic                                ras_n,
    input  logic                                cas_n,
    input  logic                                we_n,
    input  logic [ddr2_pkg::BA_BITS-1:0]        ba,
    input  logic [ddr2_pkg::ADDR_BITS-1:0]      addr,
    input  logic [ddr2_pkg::WORD_BITS-1:0]      dq_out,
    input  logic                                dq_oe,
    output logic [ddr2_pkg::WORD_BITS-1:0]      dq_in
);

    logic [ddr2_pkg::WORD_BITS-1:0] mem [int];
    // open row per bank
    logic [ddr2_pkg::ROW_BITS-1:0]  open_row [2**ddr2_pkg::BA_BITS];
    // column commands in flight, index is posedges since issue
    int                             wq [ddr2_pkg::WL+2];
    int                             rq [ddr2_pkg::RL+1];
    ddr2_pkg::ddr_cmd_u             c;

    initial begin
        dq_in <= '0;
        for (int i = 0; i < ddr2_pkg::WL+2; i++) wq[i] = -1;
        for (int i = 0; i < ddr2_pkg::RL+1; i++) rq[i] = -1;
    end

    always @(posedge clk1) begin
        c.pins = '{cs_n: cs_n, ras_n: ras_n, cas_n: cas_n, we_n: we_n};
        for (int i = ddr2_pkg::WL+1; i > 0; i--) wq[i] = wq[i-1];
        for (int i = ddr2_pkg::RL; i > 0; i--) rq[i] = rq[i-1];
        wq[0] = -1;
        rq[0] = -1;
        if (c.code == ddr2_pkg::CMD_ACT) open_row[ba] = addr[ddr2_pkg::ROW_BITS-1:0];
        if (c.code == ddr2_pkg::CMD_WRITE || c.code == ddr2_pkg::CMD_READ) begin
            // key is the flat host address {bank, row, column}
            if (c.code == ddr2_pkg::CMD_WRITE) begin
                wq[0] = {ba, open_row[ba], addr[ddr2_pkg::COL_BITS-1:0]};
            end else begin
                rq[0] = {ba, open_row[ba], addr[ddr2_pkg::COL_BITS-1:0]};
            end
        end
        // write pair lands WL and WL+1 cycles after WRITE
        if (wq[ddr2_pkg::WL] >= 0 && dq_oe) mem[wq[ddr2_pkg::WL]] = dq_out;
        if (wq[ddr2_pkg::WL+1] >= 0 && dq_oe) mem[wq[ddr2_pkg::WL+1] + 1] = dq_out;
        // read pair driven RL and RL+1 cycles after READ
        if (rq[ddr2_pkg::RL-1] >= 0) dq_in <= mem[rq[ddr2_pkg::RL-1]];
        if (rq[ddr2_pkg::RL] >= 0) dq_in <= mem[rq[ddr2_pkg::RL] + 1];
    end

endmodule

/* tests/tb_ddr2_ctrl.sv */
// testbench for the ddr2 controller; runs the test table against the DUT and a memory model
`timescale 1ns/100ps

module tb_ddr2_ctrl;

    localparam int N_TESTS = 6;
    localparam int GAP     = ddr2_pkg::REFI_CYCLES + 50;

    logic clk1 = 1'b0, rst_n = 1'b0, req_valid = 1'b0, req_write = 1'b0;
    logic [ddr2_pkg::HOST_ADDR_BITS-1:0] req_addr = '0;
    logic [ddr2_pkg::LEN_BITS-1:0]       req_len = '0;
    logic [ddr2_pkg::WORD_BITS-1:0]      wr_data = '0;
    logic req_ready, wr_ready, wr_done, rd_valid, cke, cs_n, ras_n, cas_n, we_n, dq_oe;
    logic [ddr2_pkg::WORD_BITS-1:0]      rd_data, dq_out, dq_in;
    logic [ddr2_pkg::BA_BITS-1:0]        ba;
    logic [ddr2_pkg::ADDR_BITS-1:0]      addr;

    // test table: name, write, address, length, data seed, idle gap before
    string    t_name [N_TESTS] = '{"wr_pair", "rd_pair", "wr_long", "rd_long",
                                   "rd_pair_after_ref", "rd_long_after_ref"};
    bit       t_wr   [N_TESTS] = '{1, 0, 1, 0, 0, 0};
    int       t_addr [N_TESTS];
    int       t_len  [N_TESTS] = '{1, 1, 15, 15, 1, 15};
    int       t_seed [N_TESTS] = '{3, 0, 7, 0, 0, 0};
    int       t_gap  [N_TESTS] = '{0, 0, 0, 0, GAP, GAP};

    logic [ddr2_pkg::WORD_BITS-1:0] sb [int];
    logic [ddr2_pkg::WORD_BITS-1:0] wr_buf [256];
    int          wr_idx, err_cnt, pass_cnt, fail_cnt, done_cnt, n_wr, aref_cnt, cyc;
    int          last_aref = -1, exp_col, limit;
    logic [ddr2_pkg::BA_BITS-1:0]  exp_ba;
    logic [ddr2_pkg::ROW_BITS-1:0] exp_row;
    bit          pre_all_seen, mon_on;
    string       cur_name = "reset";
    ddr2_pkg::ddr_cmd_u pin_cmd, nop_cmd;

    ddr2_ctrl i_dut (.*);
    ddr2_mem_model i_mem (.*);

    initial forever #10 clk1 = ~clk1;

    function automatic logic [31:0] lcg_next(logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_word(string what, logic [ddr2_pkg::WORD_BITS-1:0] exp,
                              logic [ddr2_pkg::WORD_BITS-1:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %h actual %h", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_cmd(string what, ddr2_pkg::ddr_cmd_u exp, ddr2_pkg::ddr_cmd_u act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %b actual %b", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %b actual %b", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_idle_outputs();
        check_bit("req_ready", 1'b0, req_ready);
        check_bit("wr_ready", 1'b0, wr_ready);
        check_bit("wr_done", 1'b0, wr_done);
        check_bit("rd_valid", 1'b0, rd_valid);
        check_bit("dq_oe", 1'b0, dq_oe);
        check_cmd("cmd", nop_cmd, pin_cmd);
    endtask

    assign pin_cmd.pins = '{cs_n: cs_n, ras_n: ras_n, cas_n: cas_n, we_n: we_n};

    // write words pulled one per cycle while wr_ready is high
    always @(negedge clk1) begin
        if (wr_ready) begin
            wr_data <= wr_buf[wr_idx];
            wr_idx++;
        end
    end

    // --------------------
    // pin command monitor
    // --------------------
    always @(negedge clk1) begin
        cyc++;
        if (wr_done) done_cnt++;
        if (mon_on) begin
            case (pin_cmd.code)
                ddr2_pkg::CMD_PRE: pre_all_seen = addr[ddr2_pkg::ALLPRE_BIT];
                ddr2_pkg::CMD_AREF: begin
                    check_bit("PRE ALL before AREF", 1'b1, pre_all_seen);
                    last_aref = cyc;
                    aref_cnt++;
                    pre_all_seen = 1'b0;
                end
                ddr2_pkg::CMD_ACT: begin
                    if (last_aref >= 0) begin
                        check_bit("tRFC kept", 1'b1, cyc - last_aref > ddr2_pkg::RFC_CYCLES);
                    end
                    check_word("act bank", 32'(exp_ba), 32'(ba));
                    check_word("act row", 32'(exp_row), 32'(addr));
                    pre_all_seen = 1'b0;
                end
                ddr2_pkg::CMD_WRITE, ddr2_pkg::CMD_READ: begin
                    check_word("column", 32'(exp_col), 32'(addr));
                    exp_col += 2;
                end
                default: ;
            endcase
        end
    end

    task automatic run_test(int t);
        int          errs = err_cnt;
        int          got = 0;
        int          key = t_addr[t];
        logic [31:0] x = 32'h890a_2d52 ^ t_seed[t];
        cur_name = t_name[t];
        repeat (t_gap[t]) @(negedge clk1);
        for (int i = 0; i <= t_len[t] && t_wr[t]; i++) begin
            x = lcg_next(x);
            wr_buf[i] = x;
            sb[key + i] = x;
        end
        {exp_ba, exp_row, exp_col} = {key[25:23], key[22:10], 32'(key[9:0])};
        wr_idx = 0;
        n_wr += t_wr[t];
        @(negedge clk1);
        {req_valid, req_write, req_addr, req_len} = {1'b1, t_wr[t], key[25:0], 8'(t_len[t])};
        while (!req_ready) @(negedge clk1);
        @(negedge clk1);
        req_valid = 1'b0;
        if (t_wr[t]) begin
            while (!wr_done) @(negedge clk1);
        end else begin
            while (got <= t_len[t]) begin
                if (rd_valid) begin
                    check_word("rd_data", sb[key + got], rd_data);
                    got++;
                end
                @(negedge clk1);
            end
            // no word beyond the burst
            repeat (4) begin
                check_bit("extra rd_valid", 1'b0, rd_valid);
                @(negedge clk1);
            end
        end
        if (err_cnt == errs) pass_cnt++;
        else fail_cnt++;
        $display("test %s: %s", t_name[t], (err_cnt == errs) ? "ok" : "errors");
    endtask

    initial begin
        logic [31:0] r = 32'h890a_2d52;
        nop_cmd.code = ddr2_pkg::CMD_NOP;
        // even column, room for 16 words without wrap
        r = lcg_next(r);
        t_addr[0] = 26'h012_3450;
        t_addr[2] = {r[25:10], r[9:5], 5'd0};
        t_addr[1] = t_addr[0];
        t_addr[4] = t_addr[0];
        t_addr[3] = t_addr[2];
        t_addr[5] = t_addr[2];
        repeat (10) begin
            @(negedge clk1);
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(negedge clk1);
        check_idle_outputs();
        check_bit("cke", 1'b1, cke);
        mon_on = 1'b1;
        for (int t = 0; t < N_TESTS; t++) run_test(t);
        repeat (20) @(negedge clk1);
        cur_name = "summary";
        check_word("wr_done count", 32'(n_wr), 32'(done_cnt));
        check_bit("two refreshes seen", 1'b1, aref_cnt >= 2);
        $display("tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) $display("SIMULATION PASSED");
        else $display("SIMULATION FAILED");
        $finish;
    end

    // watchdog sized from table lengths and refresh intervals
    initial begin
        limit = 20 + N_TESTS * (ddr2_pkg::REFI_CYCLES + 100);
        for (int t = 0; t < N_TESTS; t++) limit += (t_len[t] + 1) * 4;
        repeat (limit) @(posedge clk1);
        $display("watchdog expired after %0d cycles, a test never finished", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* compile.f */
design/ddr2_pkg.sv
design/ddr2_req_stage.sv
design/ddr2_refresh_timer.sv
design/ddr2_cmd_seq.sv
design/ddr2_data_path.sv
design/ddr2_ctrl.sv
tests/ddr2_mem_model.sv
tests/tb_ddr2_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ddr2_ctrl
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
